//--- bench/exec_patterns.hex
// columns: instruction, kind (1 write, 2 silent, 3 illegal, 0 end; 1x = no idle gap),
// expected rd, expected value
00500093 01 01 00000005
FFD00113 01 02 FFFFFFFD
123451B7 01 03 12345000
00001217 01 04 0000100C
// register-register forms
002082B3 01 05 00000002
40208333 01 06 00000008
001123B3 01 07 00000001
00113433 01 08 00000000
0020C4B3 01 09 FFFFFFF8
00115533 01 0A 07FFFFFF
401155B3 01 0B FFFFFFFF
0030E633 01 0C 12345005
0021F6B3 01 0D 12345000
00109733 01 0E 000000A0
// register-immediate forms with negative immediates
FFF12793 01 0F 00000001
FFF0B813 01 10 00000001
FFF0C893 01 11 FFFFFFFA
7F00E913 01 12 000007F5
0F017993 01 13 000000F0
00309A13 01 14 00000028
00415A93 01 15 0FFFFFFF
4024DB13 01 16 FFFFFFFE
// dependent chain issued back to back
06400B93 01 17 00000064
001B8B93 11 17 00000065
001B8B93 11 17 00000066
017B8C33 11 18 000000CC
417C0CB3 11 19 00000066
// x0 as destination and as operand
00708013 02 00 00000000
00100D33 01 1A 00000005
ABCDE037 02 00 00000000
00900D93 11 1B 00000009
// branch, load and mul are not supported
00208063 03 00 00000000
0000A283 03 00 00000000
00028E13 11 1C 00000002
02108EB3 03 00 00000000
00000E97 01 1D 0000008C
0020AF33 11 1E 00000000
0020BFB3 11 1F 00000001
00000000 00 00 00000000

//--- vlog.f
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/int_alu.sv
logic/exec_core.sv
bench/exec_core_tb.sv

//--- bench/exec_core_tb.sv
`timescale 1ns/100ps

module exec_core_tb;

	localparam int MAX_REC     = 64;
	localparam int DRAIN_LIMIT = 20;

	// record kinds in the pattern file
	// bit 4 of the kind word asks for back-to-back issue
	localparam logic [3:0] KIND_END     = 4'd0;
	localparam logic [3:0] KIND_WRITE   = 4'd1;
	localparam logic [3:0] KIND_SILENT  = 4'd2;
	localparam logic [3:0] KIND_ILLEGAL = 4'd3;

	logic                                 clk;
	logic                                 i_rst_n;
	logic                                 i_instr_valid;
	logic [rv_core_pkg::XLEN-1:0]         i_instr;
	logic                                 o_wb_valid;
	logic [rv_core_pkg::REG_ADDR_W-1:0]   o_wb_rd;
	logic [rv_core_pkg::XLEN-1:0]         o_wb_data;
	logic                                 o_illegal;

	// each record is four words of instruction, kind, rd and value
	logic [31:0] pat [0:4*MAX_REC-1];

	int rec_q[$];
	int cyc_q[$];
	int cycle_cnt;
	int event_cnt;
	int seen_cnt;

	exec_core u_dut (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.o_wb_valid    (o_wb_valid),
		.o_wb_rd       (o_wb_rd),
		.o_wb_data     (o_wb_data),
		.o_illegal     (o_illegal)
	);

	always #50 clk = ~clk;

	// rising edge count for the latency checks
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [3:0] rec_kind(input int idx);
		return pat[4*idx+1][3:0];
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("Fail at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// match each writeback or illegal pulse to the oldest pending record
	always @(negedge clk) begin
		int idx;
		int cyc;
		if (o_wb_valid || o_illegal) begin
			while (rec_q.size() > 0 && rec_kind(rec_q[0]) == KIND_SILENT) begin
				void'(rec_q.pop_front());
				void'(cyc_q.pop_front());
			end
			if (rec_q.size() == 0) begin
				$display("output seen at %0t with no instruction pending", $time);
				$display("tests failed");
				$fatal(1);
			end else begin
				idx = rec_q.pop_front();
				cyc = cyc_q.pop_front();
				check(cycle_cnt, cyc + 1, $sformatf("latency of record %0d", idx));
				if (rec_kind(idx) == KIND_ILLEGAL) begin
					check(o_illegal, 1'b1, $sformatf("illegal pulse of record %0d", idx));
					check(o_wb_valid, 1'b0, $sformatf("writeback on illegal record %0d", idx));
				end else begin
					check(o_wb_valid, 1'b1, $sformatf("writeback of record %0d", idx));
					check(o_illegal, 1'b0, $sformatf("illegal on record %0d", idx));
					check(o_wb_rd, pat[4*idx+2], $sformatf("rd of record %0d", idx));
					check(o_wb_data, pat[4*idx+3], $sformatf("data of record %0d", idx));
				end
				seen_cnt++;
			end
		end
	end

	initial begin
		int rec;
		int gap;
		int wait_cnt;
		logic [3:0] kind;

		void'($urandom(32'h92b9));
		clk           = 1'b0;
		i_rst_n       = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		cycle_cnt     = 0;
		event_cnt     = 0;
		seen_cnt      = 0;

		for (int i = 0; i < 4*MAX_REC; i++) begin
			pat[i] = '0;
		end
		$readmemh("bench/exec_patterns.hex", pat);
		if (rec_kind(0) == KIND_END) begin
			$display("pattern file holds no records");
			$display("tests failed");
			$fatal(1);
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		// idle core must stay quiet
		repeat (4) begin
			@(negedge clk);
			check(o_wb_valid, 1'b0, "writeback while idle");
			check(o_illegal, 1'b0, "illegal while idle");
		end

		rec = 0;
		while (rec < MAX_REC && rec_kind(rec) != KIND_END) begin
			kind = rec_kind(rec);
			if (kind != KIND_WRITE && kind != KIND_SILENT && kind != KIND_ILLEGAL) begin
				$display("unknown record kind %0d in record %0d", kind, rec);
				$display("tests failed");
				$fatal(1);
			end
			if (pat[4*rec+1][4]) begin
				gap = 0;
			end else begin
				gap = $urandom % 4;
			end
			repeat (gap) begin
				i_instr_valid = 1'b0;
				@(negedge clk);
			end
			i_instr_valid = 1'b1;
			i_instr       = pat[4*rec];
			rec_q.push_back(rec);
			cyc_q.push_back(cycle_cnt + 1);
			if (kind != KIND_SILENT) begin
				event_cnt++;
			end
			@(negedge clk);
			rec++;
		end
		i_instr_valid = 1'b0;
		i_instr       = '0;

		wait_cnt = 0;
		while (seen_cnt != event_cnt && wait_cnt < DRAIN_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		// a few quiet cycles catch stray outputs
		repeat (4) @(negedge clk);

		if (seen_cnt != event_cnt) begin
			$display("expected writebacks never arrived, %0d of %0d seen", seen_cnt, event_cnt);
			$display("tests failed");
			$fatal(1);
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- logic/exec_core.sv
`timescale 1ns/100ps

module exec_core (
	input  logic                                 clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_instr_valid,
	input  logic [rv_core_pkg::XLEN-1:0]         i_instr,
	output logic                                 o_wb_valid,
	output logic [rv_core_pkg::REG_ADDR_W-1:0]   o_wb_rd,
	output logic [rv_core_pkg::XLEN-1:0]         o_wb_data,
	output logic                                 o_illegal
);

	logic [rv_core_pkg::XLEN-1:0]          pc;
	logic                                  d_valid;
	logic [rv_core_pkg::REG_ADDR_W-1:0]    d_rd;
	logic [rv_core_pkg::REG_ADDR_W-1:0]    d_rs1;
	logic [rv_core_pkg::REG_ADDR_W-1:0]    d_rs2;
	logic [rv_core_pkg::XLEN-1:0]          d_imm;
	logic [rv_core_pkg::ALU_OP_W-1:0]      d_alu_op;
	logic [rv_core_pkg::TYPE_W-1:0]        d_type;
	logic                                  d_wen;
	logic                                  d_illegal;
	logic [rv_core_pkg::XLEN-1:0]          d_pc;
	logic [rv_core_pkg::XLEN-1:0]          rs1_data;
	logic [rv_core_pkg::XLEN-1:0]          rs2_data;
	logic [rv_core_pkg::XLEN-1:0]          alu_a;
	logic [rv_core_pkg::XLEN-1:0]          alu_b;
	logic [rv_core_pkg::XLEN-1:0]          alu_result;
	logic                                  wr_en;

	// pc advances once per accepted instruction
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc <= rv_core_pkg::RESET_PC;
		end else if (i_instr_valid) begin
			pc <= pc + 32'd4;
		end
	end

	instr_decoder u_decode (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_valid   (i_instr_valid),
		.i_instr   (i_instr),
		.i_pc      (pc),
		.o_valid   (d_valid),
		.o_rd      (d_rd),
		.o_rs1     (d_rs1),
		.o_rs2     (d_rs2),
		.o_imm     (d_imm),
		.o_alu_op  (d_alu_op),
		.o_type    (d_type),
		.o_wen     (d_wen),
		.o_illegal (d_illegal),
		.o_pc      (d_pc)
	);

	assign wr_en = d_valid && d_wen;

	reg_file u_regs (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_rs1      (d_rs1),
		.i_rs2      (d_rs2),
		.i_we       (wr_en),
		.i_waddr    (d_rd),
		.i_wdata    (alu_result),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	// operand a is pc for auipc and zero for lui
	always_comb begin
		alu_b = d_imm;
		case (d_type)
			rv_core_pkg::TYPE_R: begin
				alu_a = rs1_data;
				alu_b = rs2_data;
			end
			rv_core_pkg::TYPE_I: begin
				alu_a = rs1_data;
			end
			rv_core_pkg::TYPE_U: begin
				alu_a = (d_alu_op == rv_core_pkg::ALU_PASS_B) ? '0 : d_pc;
			end
			default: begin
				alu_a = '0;
			end
		endcase
	end

	int_alu u_alu (
		.i_op     (d_alu_op),
		.i_a      (alu_a),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

	// writeback register loads on the same edge as the register file write
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_valid <= 1'b0;
			o_wb_rd    <= '0;
			o_wb_data  <= '0;
			o_illegal  <= 1'b0;
		end else begin
			o_wb_valid <= wr_en;
			o_wb_rd    <= d_rd;
			o_wb_data  <= alu_result;
			o_illegal  <= d_illegal;
		end
	end

endmodule

//--- logic/int_alu.sv
`timescale 1ns/100ps

module int_alu (
	input  logic [rv_core_pkg::ALU_OP_W-1:0]   i_op,
	input  logic [rv_core_pkg::XLEN-1:0]       i_a,
	input  logic [rv_core_pkg::XLEN-1:0]       i_b,
	output logic [rv_core_pkg::XLEN-1:0]       o_result
);

	logic [4:0]                        shamt;
	logic                              lt_signed;
	logic                              lt_unsigned;

	// rv32 shifts use only the low five bits
	assign shamt = i_b[4:0];

	assign lt_signed   = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb begin
		case (i_op)
			rv_core_pkg::ALU_ADD: begin
				o_result = i_a + i_b;
			end
			rv_core_pkg::ALU_SUB: begin
				o_result = i_a - i_b;
			end
			rv_core_pkg::ALU_SLL: begin
				o_result = i_a << shamt;
			end
			rv_core_pkg::ALU_SLT: begin
				o_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_signed};
			end
			rv_core_pkg::ALU_SLTU: begin
				o_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_unsigned};
			end
			rv_core_pkg::ALU_XOR: begin
				o_result = i_a ^ i_b;
			end
			rv_core_pkg::ALU_SRL: begin
				o_result = i_a >> shamt;
			end
			// arithmetic shift keeps the sign bit
			rv_core_pkg::ALU_SRA: begin
				o_result = $unsigned($signed(i_a) >>> shamt);
			end
			rv_core_pkg::ALU_OR: begin
				o_result = i_a | i_b;
			end
			rv_core_pkg::ALU_AND: begin
				o_result = i_a & i_b;
			end
			rv_core_pkg::ALU_PASS_B: begin
				o_result = i_b;
			end
			default: begin
				o_result = '0;
			end
		endcase
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                                 clk,
	input  logic                                 i_rst_n,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0]   i_rs1,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0]   i_rs2,
	input  logic                                 i_we,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0]   i_waddr,
	input  logic [rv_core_pkg::XLEN-1:0]         i_wdata,
	output logic [rv_core_pkg::XLEN-1:0]         o_rs1_data,
	output logic [rv_core_pkg::XLEN-1:0]         o_rs2_data
);

	localparam int NUM_REGS = 2 ** rv_core_pkg::REG_ADDR_W;

	// x0 has no storage
	logic [rv_core_pkg::XLEN-1:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_waddr != '0)) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// reads see the value written at the previous edge
	always_comb begin
		if (i_rs1 == '0) begin
			o_rs1_data = '0;
		end else begin
			o_rs1_data = regs[i_rs1];
		end

		if (i_rs2 == '0) begin
			o_rs2_data = '0;
		end else begin
			o_rs2_data = regs[i_rs2];
		end
	end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
	input  logic                                 clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_valid,
	input  logic [rv_core_pkg::XLEN-1:0]         i_instr,
	input  logic [rv_core_pkg::XLEN-1:0]         i_pc,
	output logic                                 o_valid,
	output logic [rv_core_pkg::REG_ADDR_W-1:0]   o_rd,
	output logic [rv_core_pkg::REG_ADDR_W-1:0]   o_rs1,
	output logic [rv_core_pkg::REG_ADDR_W-1:0]   o_rs2,
	output logic [rv_core_pkg::XLEN-1:0]         o_imm,
	output logic [rv_core_pkg::ALU_OP_W-1:0]     o_alu_op,
	output logic [rv_core_pkg::TYPE_W-1:0]       o_type,
	output logic                                 o_wen,
	output logic                                 o_illegal,
	output logic [rv_core_pkg::XLEN-1:0]         o_pc
);

	logic [6:0]                            opcode;
	logic [2:0]                            funct3;
	logic [6:0]                            funct7;
	logic [rv_core_pkg::REG_ADDR_W-1:0]    rd;
	logic [rv_core_pkg::XLEN-1:0]          i_imm;
	logic [rv_core_pkg::XLEN-1:0]          u_imm;
	logic [rv_core_pkg::XLEN-1:0]          sh_imm;
	logic [rv_core_pkg::XLEN-1:0]          dec_imm;
	logic [rv_core_pkg::ALU_OP_W-1:0]      dec_op;
	logic [rv_core_pkg::TYPE_W-1:0]        dec_type;
	logic                                  dec_legal;
	logic                                  dec_wen;

	// base alu op for a funct3 in both register and immediate forms
	function automatic logic [rv_core_pkg::ALU_OP_W-1:0] base_op(input logic [2:0] f3);
		logic [rv_core_pkg::ALU_OP_W-1:0] op;
		case (f3)
			rv_core_pkg::F3_ADD_SUB: op = rv_core_pkg::ALU_ADD;
			rv_core_pkg::F3_SLL:     op = rv_core_pkg::ALU_SLL;
			rv_core_pkg::F3_SLT:     op = rv_core_pkg::ALU_SLT;
			rv_core_pkg::F3_SLTU:    op = rv_core_pkg::ALU_SLTU;
			rv_core_pkg::F3_XOR:     op = rv_core_pkg::ALU_XOR;
			rv_core_pkg::F3_SRL_SRA: op = rv_core_pkg::ALU_SRL;
			rv_core_pkg::F3_OR:      op = rv_core_pkg::ALU_OR;
			default:                 op = rv_core_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = i_instr[6:0];
	assign rd     = i_instr[11:7];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	// immediates for the supported formats
	assign i_imm  = {{(rv_core_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
	assign u_imm  = {i_instr[31:12], 12'b0};
	assign sh_imm = {{(rv_core_pkg::XLEN-5){1'b0}}, i_instr[24:20]};

	always_comb begin
		dec_imm   = '0;
		dec_op    = rv_core_pkg::ALU_ADD;
		dec_type  = rv_core_pkg::TYPE_NONE;
		dec_legal = 1'b1;

		case (opcode)
			rv_core_pkg::OPC_OP: begin
				dec_type = rv_core_pkg::TYPE_R;
				dec_op   = base_op(funct3);
				if (funct7 == rv_core_pkg::F7_ALT) begin
					// only add and srl have an alternate form
					if (funct3 == rv_core_pkg::F3_ADD_SUB) begin
						dec_op = rv_core_pkg::ALU_SUB;
					end else if (funct3 == rv_core_pkg::F3_SRL_SRA) begin
						dec_op = rv_core_pkg::ALU_SRA;
					end else begin
						dec_legal = 1'b0;
					end
				end else if (funct7 != rv_core_pkg::F7_BASE) begin
					dec_legal = 1'b0;
				end
			end

			rv_core_pkg::OPC_OP_IMM: begin
				dec_type = rv_core_pkg::TYPE_I;
				dec_op   = base_op(funct3);
				dec_imm  = i_imm;
				if (funct3 == rv_core_pkg::F3_SLL) begin
					dec_imm = sh_imm;
					if (funct7 != rv_core_pkg::F7_BASE) begin
						dec_legal = 1'b0;
					end
				end else if (funct3 == rv_core_pkg::F3_SRL_SRA) begin
					dec_imm = sh_imm;
					if (funct7 == rv_core_pkg::F7_ALT) begin
						dec_op = rv_core_pkg::ALU_SRA;
					end else if (funct7 != rv_core_pkg::F7_BASE) begin
						dec_legal = 1'b0;
					end
				end
			end

			rv_core_pkg::OPC_LUI: begin
				dec_type = rv_core_pkg::TYPE_U;
				dec_op   = rv_core_pkg::ALU_PASS_B;
				dec_imm  = u_imm;
			end

			// pc is added in the alu
			rv_core_pkg::OPC_AUIPC: begin
				dec_type = rv_core_pkg::TYPE_U;
				dec_op   = rv_core_pkg::ALU_ADD;
				dec_imm  = u_imm;
			end

			default: begin
				dec_legal = 1'b0;
			end
		endcase
	end

	// x0 destinations never produce a write
	assign dec_wen = dec_legal && (rd != '0);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid   <= 1'b0;
			o_illegal <= 1'b0;
			o_wen     <= 1'b0;
			o_rd      <= '0;
			o_rs1     <= '0;
			o_rs2     <= '0;
			o_imm     <= '0;
			o_alu_op  <= '0;
			o_type    <= rv_core_pkg::TYPE_NONE;
			o_pc      <= '0;
		end else begin
			o_valid   <= i_valid;
			o_illegal <= i_valid && !dec_legal;
			if (i_valid) begin
				o_wen    <= dec_wen;
				o_rd     <= rd;
				o_rs1    <= i_instr[19:15];
				o_rs2    <= i_instr[24:20];
				o_imm    <= dec_imm;
				o_alu_op <= dec_op;
				o_type   <= dec_type;
				o_pc     <= i_pc;
			end
		end
	end

endmodule

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

	// datapath and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 4;
	localparam int TYPE_W     = 2;

	// program counter after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// major opcodes handled by the decoder
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// funct3 field values shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 values where the alt form selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// alu operation codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
	// forwards operand b, used for lui
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

	// instruction format codes
	// none is zero so a reset decoder reports no format
	localparam logic [TYPE_W-1:0] TYPE_NONE = 2'd0;
	localparam logic [TYPE_W-1:0] TYPE_R    = 2'd1;
	localparam logic [TYPE_W-1:0] TYPE_I    = 2'd2;
	localparam logic [TYPE_W-1:0] TYPE_U    = 2'd3;

endpackage
